/* board_pkg.sv */
////////////////////////////////////////
// Board package
// Pad map, sizes and shared bus types for the GPIO board
////////////////////////////////////////

`default_nettype none

package board_pkg;

  // Sizes
  localparam int NumGpio       = 16;
  localparam int NumPads       = 22;
  localparam int ScanLen       = 48;
  localparam int RstHoldCycles = 4;
  localparam int RstCntW       = $clog2(RstHoldCycles + 1);

  // Pad indices above the GPIO block
  localparam int PadJtagEn = 16;
  localparam int PadTck    = 17;
  localparam int PadTms    = 18;
  localparam int PadTdi    = 19;
  localparam int PadTdo    = 20;
  localparam int PadSrstN  = 21;

  // Core-side values on JTAG pads while the overlay is active
  localparam logic [NumPads-1:0] PadTieOff = (NumPads'(1) << PadTms) |
                                             (NumPads'(1) << PadSrstN);

  // Strap and JTAG inputs taken away from the core
  localparam logic [NumPads-1:0] JtagPadMask = (NumPads'(1) << PadJtagEn) |
                                               (NumPads'(1) << PadTck)    |
                                               (NumPads'(1) << PadTms)    |
                                               (NumPads'(1) << PadTdi)    |
                                               (NumPads'(1) << PadSrstN);

  typedef struct packed {
    logic [NumPads-1:0] out;
    logic [NumPads-1:0] oe;
  } pad_drive_t;

  typedef struct packed {
    logic [NumPads-1:0] invert; // Only GPIO bits settable
  } pad_attr_t;

  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic srst_n;
  } jtag_bus_t;

  localparam jtag_bus_t JtagIdle = '{tck: 1'b0, tms: 1'b1, tdi: 1'b0, srst_n: 1'b1};

endpackage : board_pkg

`default_nettype wire

/* io_ring.sv */
////////////////////////////////////////
// Pad ring
// Input synchronizer and per-pad polarity inversion
////////////////////////////////////////

`default_nettype none

module io_ring (
  input  logic                          clk_main_i,
  input  logic                          rst_n_i,
  // Board side
  input  logic [board_pkg::NumPads-1:0] pad_in_i,
  output logic [board_pkg::NumPads-1:0] pad_out_o,
  output logic [board_pkg::NumPads-1:0] pad_oe_o,
  // Core side
  input  board_pkg::pad_drive_t         core_drive_i,
  input  board_pkg::pad_attr_t          pad_attr_i,
  output logic [board_pkg::NumPads-1:0] pad_in_sync_o
);

  import board_pkg::*;

  logic [NumPads-1:0] sync_q1;
  logic [NumPads-1:0] sync_q2;

  ////////////////////////////////////////
  // Input path
  ////////////////////////////////////////

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_in_i;
      sync_q2 <= sync_q1;
    end
  end

  // Inversion after the flops, so attribute changes act at once
  assign pad_in_sync_o = sync_q2 ^ pad_attr_i.invert;

  ////////////////////////////////////////
  // Output path
  ////////////////////////////////////////

  assign pad_out_o = core_drive_i.out ^ pad_attr_i.invert;
  assign pad_oe_o  = core_drive_i.oe;  // Enables never inverted

endmodule : io_ring

`default_nettype wire

/* jtag_overlay_mux.sv */
////////////////////////////////////////
// JTAG overlay mux
// Hands the JTAG pads to the scan port when the strap is set
////////////////////////////////////////

`default_nettype none

module jtag_overlay_mux (
  input  logic                          clk_main_i,
  input  logic                          rst_n_i,
  // Pad ring side
  input  logic [board_pkg::NumPads-1:0] pad_in_i,
  output board_pkg::pad_drive_t         pad_drive_o,
  // Core side
  output logic [board_pkg::NumPads-1:0] core_in_o,
  input  board_pkg::pad_drive_t         core_drive_i,
  // Scan port
  output board_pkg::jtag_bus_t          jtag_o,
  input  logic                          jtag_tdo_i
);

  import board_pkg::*;

  logic jtag_en_q;

  // Strap registered once more so a glitch cannot flip the mux mid-cycle
  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      jtag_en_q <= 1'b0;
    end else begin
      jtag_en_q <= pad_in_i[PadJtagEn];
    end
  end

  ////////////////////////////////////////
  // Overlay
  ////////////////////////////////////////

  always_comb begin
    // Default is plain pass-through with an idle scan port
    core_in_o   = pad_in_i;
    pad_drive_o = core_drive_i;
    jtag_o      = JtagIdle;

    if (jtag_en_q) begin
      jtag_o.tck    = pad_in_i[PadTck];
      jtag_o.tms    = pad_in_i[PadTms];
      jtag_o.tdi    = pad_in_i[PadTdi];
      jtag_o.srst_n = pad_in_i[PadSrstN];

      // Core sees tie-offs in place of the taken pads
      core_in_o = (pad_in_i & ~JtagPadMask) | (PadTieOff & JtagPadMask);

      // Core drive removed from the JTAG pads
      pad_drive_o.out = core_drive_i.out & ~JtagPadMask;
      pad_drive_o.oe  = core_drive_i.oe & ~JtagPadMask;

      // TDO pad owned by the scan port
      pad_drive_o.out[PadTdo] = jtag_tdo_i;
      pad_drive_o.oe[PadTdo]  = 1'b1;
    end
  end

endmodule : jtag_overlay_mux

`default_nettype wire

/* reset_gen.sv */
////////////////////////////////////////
// Reset generator
// Merges board and JTAG system reset, stretches the release
////////////////////////////////////////

`default_nettype none

module reset_gen (
  input  logic clk_main_i,
  input  logic rst_n_i,      // Board reset
  input  logic srst_n_i,     // System reset from the scan port
  output logic rst_core_n_o
);

  import board_pkg::*;

  logic [RstCntW-1:0] hold_cnt_q;
  logic               rst_core_n_q;

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i || !srst_n_i) begin
      hold_cnt_q   <= RstCntW'(RstHoldCycles);  // Reload while any source active
      rst_core_n_q <= 1'b0;
    end else begin
      if (hold_cnt_q != '0) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end
      rst_core_n_q <= (hold_cnt_q == '0);
    end
  end

  assign rst_core_n_o = rst_core_n_q;

endmodule : reset_gen

`default_nettype wire

/* gpio_scan_core.sv */
////////////////////////////////////////
// GPIO scan core
// 48-bit scan register driving GPIO out, enable and invert
////////////////////////////////////////

`default_nettype none

module gpio_scan_core (
  input  logic                          clk_main_i,
  input  logic                          rst_n_i,
  input  logic [board_pkg::NumGpio-1:0] gpio_in_i,
  input  board_pkg::jtag_bus_t          jtag_i,
  output logic                          jtag_tdo_o,
  output board_pkg::pad_drive_t         core_drive_o,
  output board_pkg::pad_attr_t          pad_attr_o
);

  import board_pkg::*;

  logic               tck_q;
  logic               tck_qq;
  logic               tms_q;
  logic               tdi_q;
  logic               tck_rise;
  logic [ScanLen-1:0] scan_q;
  logic [NumGpio-1:0] out_q;
  logic [NumGpio-1:0] oe_q;
  logic [NumGpio-1:0] inv_q;

  ////////////////////////////////////////
  // TCK edge detect
  ////////////////////////////////////////

  // TMS and TDI delayed together with TCK to stay aligned
  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      tck_q  <= 1'b0;
      tck_qq <= 1'b0;
      tms_q  <= 1'b1;
      tdi_q  <= 1'b0;
    end else begin
      tck_q  <= jtag_i.tck;
      tck_qq <= tck_q;
      tms_q  <= jtag_i.tms;
      tdi_q  <= jtag_i.tdi;
    end
  end

  assign tck_rise = tck_q & ~tck_qq;

  ////////////////////////////////////////
  // Shift, update and capture
  ////////////////////////////////////////

  always_ff @(posedge clk_main_i) begin
    if (!rst_n_i) begin
      scan_q <= '0;
      out_q  <= '0;
      oe_q   <= '0;
      inv_q  <= '0;
    end else if (tck_rise) begin
      if (tms_q) begin
        // Update from the scan word, then capture inputs into the low field
        out_q                <= scan_q[NumGpio-1:0];
        oe_q                 <= scan_q[2*NumGpio-1:NumGpio];
        inv_q                <= scan_q[3*NumGpio-1:2*NumGpio];
        scan_q[NumGpio-1:0]  <= gpio_in_i;
      end else begin
        scan_q <= {tdi_q, scan_q[ScanLen-1:1]};  // TDI in at MSB
      end
    end
  end

  assign jtag_tdo_o = scan_q[0];

  // Upper pad bits stay zero
  assign core_drive_o.out  = NumPads'(out_q);
  assign core_drive_o.oe   = NumPads'(oe_q);
  assign pad_attr_o.invert = NumPads'(inv_q);

endmodule : gpio_scan_core

`default_nettype wire

/* board_top.sv */
////////////////////////////////////////
// Board top level
// Pad ring, JTAG overlay, reset and scan core
////////////////////////////////////////

`default_nettype none

module board_top (
  input  logic                          clk_main_i,
  input  logic                          rst_n_i,
  input  logic [board_pkg::NumPads-1:0] pad_in_i,
  output logic [board_pkg::NumPads-1:0] pad_out_o,
  output logic [board_pkg::NumPads-1:0] pad_oe_o
);

  import board_pkg::*;

  logic [NumPads-1:0] pad_in_sync;
  logic [NumPads-1:0] core_in;
  pad_drive_t         core_drive;   // From core, before the overlay
  pad_drive_t         pad_drive;    // To pad ring, after the overlay
  pad_attr_t          pad_attr;
  jtag_bus_t          jtag_bus;
  logic               jtag_tdo;
  logic               rst_core_n;

  io_ring io_ring_inst (
    .clk_main_i    ( clk_main_i  ),
    .rst_n_i       ( rst_n_i     ),
    .pad_in_i      ( pad_in_i    ),
    .pad_out_o     ( pad_out_o   ),
    .pad_oe_o      ( pad_oe_o    ),
    .core_drive_i  ( pad_drive   ),
    .pad_attr_i    ( pad_attr    ),
    .pad_in_sync_o ( pad_in_sync )
  );

  jtag_overlay_mux jtag_overlay_mux_inst (
    .clk_main_i   ( clk_main_i  ),
    .rst_n_i      ( rst_n_i     ),
    .pad_in_i     ( pad_in_sync ),
    .pad_drive_o  ( pad_drive   ),
    .core_in_o    ( core_in     ),
    .core_drive_i ( core_drive  ),
    .jtag_o       ( jtag_bus    ),
    .jtag_tdo_i   ( jtag_tdo    )
  );

  reset_gen reset_gen_inst (
    .clk_main_i   ( clk_main_i      ),
    .rst_n_i      ( rst_n_i         ),
    .srst_n_i     ( jtag_bus.srst_n ),
    .rst_core_n_o ( rst_core_n      )
  );

  gpio_scan_core gpio_scan_core_inst (
    .clk_main_i   ( clk_main_i             ),
    .rst_n_i      ( rst_core_n             ),
    .gpio_in_i    ( core_in[NumGpio-1:0]   ),
    .jtag_i       ( jtag_bus               ),
    .jtag_tdo_o   ( jtag_tdo               ),
    .core_drive_o ( core_drive             ),
    .pad_attr_o   ( pad_attr               )
  );

endmodule : board_top

`default_nettype wire

/* board_top_sva.sv */
////////////////////////////////////////
// Assertions on overlay and reset
////////////////////////////////////////

`default_nettype none

module board_top_sva (
  input logic                          clk_main_i,
  input logic                          rst_n_i,
  input logic [board_pkg::NumPads-1:0] pad_in_i,
  input logic [board_pkg::NumPads-1:0] pad_oe_i,
  input logic                          srst_n_i,
  input logic                          rst_core_n_i
);
  timeunit 1ns;
  timeprecision 1ps;

  import board_pkg::*;

  logic src_ok;
  assign src_ok = rst_n_i & srst_n_i;

  // Strap low through the sync chain means TDO released
  tdo_off_a: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    (!pad_in_i[PadJtagEn])[*4] |-> !pad_oe_i[PadTdo])
    else $error("TDO enabled with strap low");

  rst_hold_a: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    $rose(rst_core_n_i) |-> $past(src_ok, 1) && $past(src_ok, 2) &&
                            $past(src_ok, 3) && $past(src_ok, RstHoldCycles))
    else $error("Core reset released too early");

  oe_in_reset_a: assert property (@(posedge clk_main_i) disable iff (!rst_n_i)
    (!rst_core_n_i && $past(!rst_core_n_i)) |-> pad_oe_i[NumGpio-1:0] == '0)
    else $error("GPIO enable set during core reset");

endmodule : board_top_sva

bind board_top board_top_sva board_top_sva_inst (
  .clk_main_i   ( clk_main_i      ),
  .rst_n_i      ( rst_n_i         ),
  .pad_in_i     ( pad_in_i        ),
  .pad_oe_i     ( pad_oe_o        ),
  .srst_n_i     ( jtag_bus.srst_n ),
  .rst_core_n_i ( rst_core_n      )
);

`default_nettype wire

/* tb_board_top.sv */
////////////////////////////////////////
// Testbench for the GPIO board top level
// Scan writes, captures, strap and reset checks
////////////////////////////////////////

`default_nettype none

module tb_board_top;
  timeunit 1ns;
  timeprecision 1ps;

  import board_pkg::*;

  logic               clk_main_i;
  logic               rst_n_i;
  logic [NumPads-1:0] pad_in;
  logic [NumPads-1:0] pad_out;
  logic [NumPads-1:0] pad_oe;
  logic [31:0]        lcg_state;
  logic [47:0]        word;
  logic [47:0]        exp_pads;
  logic [15:0]        gin;
  logic [15:0]        tdo_bits;
  int                 err_count;
  int                 check_count;
  int                 timeout_count;

  board_top board_top_inst (
    .clk_main_i ( clk_main_i ),
    .rst_n_i    ( rst_n_i    ),
    .pad_in_i   ( pad_in     ),
    .pad_out_o  ( pad_out    ),
    .pad_oe_o   ( pad_oe     )
  );

  initial begin
    clk_main_i = 1'b0;
    forever #20 clk_main_i = ~clk_main_i;  // 40 ns period
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Expected {captured inputs, enables, pad outputs} for a scan word
  function automatic logic [47:0] expect_pads(input logic [47:0] w, input logic [15:0] g);
    logic [15:0] inv;
    inv = w[47:32];
    return {g ^ inv, w[31:16], w[15:0] ^ inv};
  endfunction

  task automatic next_cycles(input int n);
    repeat (n) @(posedge clk_main_i);
    #2;  // Drive just after the edge
  endtask

  task automatic check_equal(input logic [47:0] got, input logic [47:0] exp, input string msg);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("[FAIL] %0t ns: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic random_word(output logic [47:0] w);
    for (int i = 0; i < 3; i++) begin
      lcg_state = lcg_next(lcg_state);
      w[16*i +: 16] = lcg_state[31:16];
    end
  endtask

  task automatic wait_tdo_oe(input logic value);
    int n;
    n = 0;
    while (pad_oe[PadTdo] !== value && n < 50) begin
      next_cycles(1);
      n++;
    end
    if (pad_oe[PadTdo] !== value) begin
      timeout_count++;
      $display("Timeout: TDO pad enable never became %0b", value);
    end
  endtask

  task automatic wait_core_release();
    int n;
    n = 0;
    while (board_top_inst.rst_core_n !== 1'b1 && n < 50) begin
      next_cycles(1);
      n++;
    end
    if (board_top_inst.rst_core_n !== 1'b1) begin
      timeout_count++;
      $display("Timeout: core reset was never released");
    end
  endtask

  // One TCK period with eight clocks per phase
  task automatic tck_pulse(input logic tms, input logic tdi);
    pad_in[PadTms] = tms;
    pad_in[PadTdi] = tdi;
    pad_in[PadTck] = 1'b0;
    next_cycles(8);
    pad_in[PadTck] = 1'b1;
    next_cycles(8);
    pad_in[PadTck] = 1'b0;
  endtask

  task automatic shift_word(input logic [47:0] w);
    for (int i = 0; i < ScanLen; i++) begin
      tck_pulse(1'b0, w[i]);  // LSB first so w[0] lands in scan bit 0
    end
  endtask

  task automatic scan_update();
    tck_pulse(1'b1, 1'b0);
  endtask

  task automatic write_and_check(input logic [47:0] w);
    shift_word(w);
    scan_update();
    exp_pads = expect_pads(w, pad_in[15:0]);
    check_equal(48'(pad_out[15:0]), 48'(exp_pads[15:0]), "GPIO outputs");
    check_equal(48'(pad_oe[15:0]), 48'(exp_pads[31:16]), "GPIO enables");
  endtask

  ////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////

  initial begin
    err_count      = 0;
    check_count    = 0;
    timeout_count  = 0;
    lcg_state      = 32'd57;
    rst_n_i        = 1'b0;
    pad_in         = '0;
    pad_in[PadTms]   = 1'b1;
    pad_in[PadSrstN] = 1'b1;
    next_cycles(8);
    rst_n_i = 1'b1;
    wait_core_release();
    check_equal(48'(pad_oe), 48'(0), "Enables after reset");
    check_equal(48'(pad_out), 48'(0), "Outputs after reset");

    pad_in[PadJtagEn] = 1'b1;
    wait_tdo_oe(1'b1);
    next_cycles(4);  // Settling gap
    check_equal(48'(pad_oe), 48'(NumPads'(1) << PadTdo), "Enables with strap set");

    random_word(word);
    write_and_check(word);

    // Capture path with the invert field kept by writing the same word again
    random_word(exp_pads);
    gin = exp_pads[15:0];
    pad_in[15:0] = gin;
    shift_word(word);
    scan_update();
    exp_pads = expect_pads(word, gin);
    for (int i = 0; i < NumGpio; i++) begin
      tdo_bits[i] = pad_out[PadTdo];
      tck_pulse(1'b0, 1'b0);
    end
    check_equal(48'(tdo_bits), 48'(exp_pads[47:32]), "Captured inputs on TDO");

    // Scan port ignored while the strap is low
    pad_in[PadJtagEn] = 1'b0;
    wait_tdo_oe(1'b0);
    for (int i = 0; i < 4; i++) begin
      tck_pulse(1'b1, 1'b0);
      tck_pulse(1'b0, 1'b1);
    end
    check_equal(48'(pad_out[15:0]), 48'(exp_pads[15:0]), "Outputs with strap low");
    check_equal(48'(pad_oe[15:0]), 48'(exp_pads[31:16]), "Enables with strap low");

    // System reset through the SRSTN pad
    pad_in[PadJtagEn] = 1'b1;
    wait_tdo_oe(1'b1);
    pad_in[PadSrstN] = 1'b0;
    next_cycles(6);
    pad_in[PadSrstN] = 1'b1;
    wait_core_release();
    check_equal(48'(pad_out[15:0]), 48'(0), "Outputs after system reset");
    check_equal(48'(pad_oe[15:0]), 48'(0), "Enables after system reset");

    for (int k = 0; k < 20; k++) begin
      random_word(word);
      write_and_check(word);
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_board_top

`default_nettype wire

/* tb.f */
board_pkg.sv
io_ring.sv
jtag_overlay_mux.sv
reset_gen.sv
gpio_scan_core.sv
board_top.sv
board_top_sva.sv
tb_board_top.sv

/* run.sh */
#!/bin/sh
# Build and run the board testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module tb_board_top -f tb.f -o sim_board \
  || { echo "Build failed"; exit 1; }

./obj_dir/sim_board > sim.log 2>&1
cat sim.log

grep -q "TESTS PASSED" sim.log && ! grep -q "TESTS FAILED" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
